// ==== rtl/cpu_pkg.sv ====
package cpu_pkg;

   // ==============================
   // widths
   // ==============================
   localparam int INSTR_W   = 16;
   localparam int DATA_W    = 16;
   localparam int OP_W      = 5;
   localparam int REG_AW    = 3;
   localparam int MEM_AW    = 8;
   localparam int NUM_REGS  = 1 << REG_AW;
   localparam int MEM_WORDS = 1 << MEM_AW;

   // ==============================
   // encodings
   // ==============================
   typedef enum logic [OP_W-1:0] {
      OP_NOP  = 5'd0,
      OP_ADD  = 5'd1,
      OP_SUB  = 5'd2,
      OP_AND  = 5'd3,
      OP_XOR  = 5'd4,
      OP_ADDI = 5'd5,
      OP_SLT  = 5'd6,
      OP_SEQ  = 5'd7,
      OP_LBI  = 5'd8,
      OP_SLBI = 5'd9,
      OP_ST   = 5'd10,
      OP_LD   = 5'd11,
      OP_HALT = 5'd12
   } opcode_e;

   // writeback source
   typedef enum logic [1:0] {
      WB_ALU = 2'd0,
      WB_MEM = 2'd1,
      WB_SET = 2'd2
   } wr_sel_e;

   // ==============================
   // stage structs
   // ==============================
   typedef struct packed {
      logic              valid;
      opcode_e           op;
      logic [REG_AW-1:0] rd;
      logic [DATA_W-1:0] rd_data_1;
      logic [DATA_W-1:0] rd_data_2;
      logic [DATA_W-1:0] sext_imm;
      logic              wr_en;
      logic              mem_wr;
      logic              mem_en;
      wr_sel_e           wr_sel;
      logic              halt;
   } id_ex_t;

   typedef struct packed {
      logic              valid;
      logic [DATA_W-1:0] alu_out;
      logic [DATA_W-1:0] rd_data_2;
      logic              alu_zero;
      logic              alu_ltz;
      logic              set;
      logic [REG_AW-1:0] wr_reg;
      logic              wr_en;
      logic              mem_wr;
      logic              mem_en;
      wr_sel_e           wr_sel;
      logic              halt;
   } ex_mem_t;

   // valid here means a register write
   typedef struct packed {
      logic              valid;
      logic [REG_AW-1:0] wr_reg;
      logic [DATA_W-1:0] wr_data;
   } wb_t;

endpackage

// ==== rtl/decode_stage.sv ====
`timescale 1ns/1ps

module decode_stage (
   input  logic                        clk,
   input  logic                        rst,
   input  logic                        instr_valid,
   input  logic [cpu_pkg::INSTR_W-1:0] instr,
   input  logic                        halted,
   input  cpu_pkg::wb_t                wb,
   output cpu_pkg::id_ex_t             id_ex
);

   logic [cpu_pkg::DATA_W-1:0] regs [cpu_pkg::NUM_REGS];

   cpu_pkg::opcode_e           op;
   logic [cpu_pkg::REG_AW-1:0] rd_addr;
   logic [cpu_pkg::REG_AW-1:0] rs_addr;
   logic [cpu_pkg::REG_AW-1:0] rt_addr;
   logic [cpu_pkg::REG_AW-1:0] rd2_addr;
   logic                       accept;
   logic                       halt_taken;
   cpu_pkg::id_ex_t            id_next;

   assign op      = cpu_pkg::opcode_e'(instr[cpu_pkg::INSTR_W-1 -: cpu_pkg::OP_W]);
   assign rd_addr = instr[10:8];
   assign rs_addr = instr[7:5];
   assign rt_addr = instr[4:2];

   // ST and SLBI need rd as the second operand
   assign rd2_addr = (op == cpu_pkg::OP_ST || op == cpu_pkg::OP_SLBI) ? rd_addr : rt_addr;

   // nothing enters behind a HALT
   assign accept = instr_valid && !halted && !halt_taken;

   // ==============================
   // decode and operand read
   // ==============================
   always_comb begin
      id_next           = '0;
      id_next.valid     = accept;
      id_next.op        = op;
      id_next.rd        = rd_addr;
      id_next.wr_sel    = cpu_pkg::WB_ALU;
      // write-through from wb
      id_next.rd_data_1 = (wb.valid && wb.wr_reg == rs_addr) ? wb.wr_data : regs[rs_addr];
      id_next.rd_data_2 = (wb.valid && wb.wr_reg == rd2_addr) ? wb.wr_data : regs[rd2_addr];

      case (op)
         cpu_pkg::OP_LBI:  id_next.sext_imm = {{8{instr[7]}}, instr[7:0]};
         cpu_pkg::OP_SLBI: id_next.sext_imm = {8'b0, instr[7:0]};
         default:          id_next.sext_imm = {{11{instr[4]}}, instr[4:0]};
      endcase

      case (op)
         cpu_pkg::OP_ADD, cpu_pkg::OP_SUB, cpu_pkg::OP_AND, cpu_pkg::OP_XOR,
         cpu_pkg::OP_ADDI, cpu_pkg::OP_LBI, cpu_pkg::OP_SLBI: begin
            id_next.wr_en = accept;
         end
         cpu_pkg::OP_SLT, cpu_pkg::OP_SEQ: begin
            id_next.wr_en  = accept;
            id_next.wr_sel = cpu_pkg::WB_SET;
         end
         cpu_pkg::OP_ST: begin
            id_next.mem_wr = accept;
            id_next.mem_en = accept;
         end
         cpu_pkg::OP_LD: begin
            id_next.wr_en  = accept;
            id_next.mem_en = accept;
            id_next.wr_sel = cpu_pkg::WB_MEM;
         end
         cpu_pkg::OP_HALT: id_next.halt = accept;
         default: ;
      endcase
   end

   // register file written from wb
   always_ff @(posedge clk) begin
      if (rst) begin
         for (int i = 0; i < cpu_pkg::NUM_REGS; i++) begin
            regs[i] <= '0;
         end
      end else if (wb.valid) begin
         regs[wb.wr_reg] <= wb.wr_data;
      end
   end

   // decode/execute register
   always_ff @(posedge clk) begin
      if (rst) begin
         id_ex.valid  <= 1'b0;
         id_ex.wr_en  <= 1'b0;
         id_ex.mem_wr <= 1'b0;
         id_ex.mem_en <= 1'b0;
         id_ex.halt   <= 1'b0;
         halt_taken   <= 1'b0;
      end else begin
         id_ex <= id_next;
         if (id_next.halt) begin
            halt_taken <= 1'b1;
         end
      end
   end

endmodule

// ==== rtl/execute_stage.sv ====
`timescale 1ns/1ps

module execute_stage (
   input  cpu_pkg::id_ex_t  id_ex,
   output cpu_pkg::ex_mem_t ex_next
);

   logic [cpu_pkg::DATA_W-1:0] a;
   logic [cpu_pkg::DATA_W-1:0] b;
   logic [cpu_pkg::DATA_W-1:0] imm;
   logic [cpu_pkg::DATA_W-1:0] diff;
   logic [cpu_pkg::DATA_W-1:0] alu;
   logic                       zero;
   logic                       ltz;
   logic                       sub_ofl;
   logic                       set;

   assign a    = id_ex.rd_data_1;
   assign b    = id_ex.rd_data_2;
   assign imm  = id_ex.sext_imm;
   assign diff = a - b;

   // ==============================
   // ALU
   // ==============================
   always_comb begin
      case (id_ex.op)
         cpu_pkg::OP_ADD:  alu = a + b;
         cpu_pkg::OP_SUB:  alu = diff;
         cpu_pkg::OP_AND:  alu = a & b;
         cpu_pkg::OP_XOR:  alu = a ^ b;
         cpu_pkg::OP_ADDI,
         cpu_pkg::OP_ST,
         cpu_pkg::OP_LD:   alu = a + imm;
         // compares run through the subtractor
         cpu_pkg::OP_SLT,
         cpu_pkg::OP_SEQ:  alu = diff;
         cpu_pkg::OP_LBI:  alu = imm;
         cpu_pkg::OP_SLBI: alu = {b[7:0], imm[7:0]};
         default:          alu = a;
      endcase
   end

   assign zero = (alu == '0);
   assign ltz  = alu[cpu_pkg::DATA_W-1];

   // signed overflow of a - b
   assign sub_ofl = (a[cpu_pkg::DATA_W-1] != b[cpu_pkg::DATA_W-1]) &&
                    (diff[cpu_pkg::DATA_W-1] != a[cpu_pkg::DATA_W-1]);

   always_comb begin
      case (id_ex.op)
         cpu_pkg::OP_SEQ: set = zero;
         cpu_pkg::OP_SLT: set = ltz ^ sub_ofl;
         default:         set = 1'b0;
      endcase
   end

   // ==============================
   // outgoing struct
   // ==============================
   always_comb begin
      ex_next.valid     = id_ex.valid;
      ex_next.alu_out   = alu;
      ex_next.rd_data_2 = b;
      ex_next.alu_zero  = zero;
      ex_next.alu_ltz   = ltz;
      ex_next.set       = set;
      ex_next.wr_reg    = id_ex.rd;
      ex_next.wr_en     = id_ex.wr_en;
      ex_next.mem_wr    = id_ex.mem_wr;
      ex_next.mem_en    = id_ex.mem_en;
      ex_next.wr_sel    = id_ex.wr_sel;
      ex_next.halt      = id_ex.halt;
   end

endmodule

// ==== rtl/ex_mem.sv ====
`timescale 1ns/1ps

module ex_mem (
   input  logic             clk,
   input  logic             rst,
   input  cpu_pkg::ex_mem_t ex_next,
   output cpu_pkg::ex_mem_t ex_q
);

   cpu_pkg::ex_mem_t bubbled;

   // invalid cycle becomes a bubble with no side effects
   always_comb begin
      bubbled = ex_next;
      if (!ex_next.valid) begin
         bubbled.wr_en  = 1'b0;
         bubbled.mem_wr = 1'b0;
         bubbled.mem_en = 1'b0;
         bubbled.halt   = 1'b0;
      end
   end

   // ==============================
   // pipeline register
   // ==============================
   always_ff @(posedge clk) begin
      if (rst) begin
         ex_q.valid  <= 1'b0;
         ex_q.wr_en  <= 1'b0;
         ex_q.mem_wr <= 1'b0;
         ex_q.mem_en <= 1'b0;
         ex_q.halt   <= 1'b0;
      end else begin
         ex_q <= bubbled;
      end
   end

endmodule

// ==== rtl/memory_stage.sv ====
`timescale 1ns/1ps

module memory_stage (
   input  logic             clk,
   input  logic             rst,
   input  cpu_pkg::ex_mem_t ex_q,
   output cpu_pkg::wb_t     wb,
   output logic             halted
);

   logic [cpu_pkg::DATA_W-1:0] mem [cpu_pkg::MEM_WORDS];

   logic [cpu_pkg::MEM_AW-1:0] addr;
   logic [cpu_pkg::DATA_W-1:0] mem_rdata;
   logic [cpu_pkg::DATA_W-1:0] wr_data;

   // low byte of the effective address
   assign addr = ex_q.alu_out[cpu_pkg::MEM_AW-1:0];

   assign mem_rdata = ex_q.mem_en ? mem[addr] : '0;

   // ==============================
   // data memory
   // ==============================
   always_ff @(posedge clk) begin
      if (rst) begin
         for (int i = 0; i < cpu_pkg::MEM_WORDS; i++) begin
            mem[i] <= '0;
         end
      end else if (ex_q.mem_wr) begin
         mem[addr] <= ex_q.rd_data_2;
      end
   end

   // writeback select
   always_comb begin
      case (ex_q.wr_sel)
         cpu_pkg::WB_MEM: wr_data = mem_rdata;
         cpu_pkg::WB_SET: wr_data = {{(cpu_pkg::DATA_W-1){1'b0}}, ex_q.set};
         default:         wr_data = ex_q.alu_out;
      endcase
   end

   // ==============================
   // mem/wb register and halt
   // ==============================
   always_ff @(posedge clk) begin
      if (rst) begin
         wb.valid <= 1'b0;
      end else begin
         wb.valid <= ex_q.valid && ex_q.wr_en;
      end
      wb.wr_reg  <= ex_q.wr_reg;
      wb.wr_data <= wr_data;
   end

   // sticky until reset
   always_ff @(posedge clk) begin
      if (rst) begin
         halted <= 1'b0;
      end else if (ex_q.valid && ex_q.halt) begin
         halted <= 1'b1;
      end
   end

endmodule

// ==== rtl/cpu_backend_top.sv ====
`timescale 1ns/1ps

module cpu_backend_top (
   input  logic                        clk,
   input  logic                        rst,
   input  logic                        instr_valid,
   input  logic [cpu_pkg::INSTR_W-1:0] instr,
   output cpu_pkg::wb_t                wb,
   output logic                        halted
);

   cpu_pkg::id_ex_t  id_ex;
   cpu_pkg::ex_mem_t ex_next;
   cpu_pkg::ex_mem_t ex_q;

   decode_stage u_decode (
      .clk         (clk),
      .rst         (rst),
      .instr_valid (instr_valid),
      .instr       (instr),
      .halted      (halted),
      .wb          (wb),
      .id_ex       (id_ex)
   );

   execute_stage u_execute (
      .id_ex   (id_ex),
      .ex_next (ex_next)
   );

   ex_mem u_ex_mem (
      .clk     (clk),
      .rst     (rst),
      .ex_next (ex_next),
      .ex_q    (ex_q)
   );

   // wb loops back into decode for the register write
   memory_stage u_memory (
      .clk    (clk),
      .rst    (rst),
      .ex_q   (ex_q),
      .wb     (wb),
      .halted (halted)
   );

endmodule

// ==== tests/tb_cpu_backend.sv ====
`timescale 1ns/1ps

module tb_cpu_backend;

   localparam int N_INSTR     = 110;
   localparam int CYCLE_LIMIT = 3 * N_INSTR + 50;

   logic                        clk;
   logic                        rst;
   logic                        instr_valid;
   logic [cpu_pkg::INSTR_W-1:0] instr;
   cpu_pkg::wb_t                wb;
   logic                        halted;

   logic [cpu_pkg::DATA_W-1:0] model_regs [cpu_pkg::NUM_REGS];
   logic [cpu_pkg::DATA_W-1:0] model_mem [cpu_pkg::MEM_WORDS];
   logic                       model_halted;
   cpu_pkg::wb_t               expected_q [$];

   integer seed = 80149;
   int     errors = 0;
   int     checks = 0;
   int     stray_wb = 0;
   int     cycles = 0;
   int     tests_passed = 0;
   int     tests_failed = 0;

   cpu_backend_top DUT (
      .clk         (clk),
      .rst         (rst),
      .instr_valid (instr_valid),
      .instr       (instr),
      .wb          (wb),
      .halted      (halted)
   );

   always #10 clk = ~clk;

   // ==============================
   // encoders and reference model
   // ==============================
   function automatic logic [15:0] rtype(cpu_pkg::opcode_e op, logic [2:0] rd,
                                         logic [2:0] rs, logic [2:0] rt);
      return {op, rd, rs, rt, 2'b00};
   endfunction

   function automatic logic [15:0] itype(cpu_pkg::opcode_e op, logic [2:0] rd,
                                         logic [2:0] rs, logic [4:0] imm);
      return {op, rd, rs, imm};
   endfunction

   function automatic logic [15:0] btype(cpu_pkg::opcode_e op, logic [2:0] rd,
                                         logic [7:0] imm);
      return {op, rd, imm};
   endfunction

   // returns the expected wb of one instruction and updates the model state
   function automatic cpu_pkg::wb_t predict(logic [15:0] ins);
      cpu_pkg::wb_t r;
      logic [4:0]   op;
      logic [2:0]   rd;
      logic [15:0]  a;
      logic [15:0]  b;
      logic [15:0]  imm5;
      logic [15:0]  sum;
      r     = '0;
      op    = ins[15:11];
      rd    = ins[10:8];
      a     = model_regs[ins[7:5]];
      b     = model_regs[ins[4:2]];
      imm5  = {{11{ins[4]}}, ins[4:0]};
      sum   = a + imm5;
      if (model_halted) begin
         return r;
      end
      r.valid  = 1'b1;
      r.wr_reg = rd;
      case (op)
         cpu_pkg::OP_ADD:  r.wr_data = a + b;
         cpu_pkg::OP_SUB:  r.wr_data = a - b;
         cpu_pkg::OP_AND:  r.wr_data = a & b;
         cpu_pkg::OP_XOR:  r.wr_data = a ^ b;
         cpu_pkg::OP_ADDI: r.wr_data = sum;
         cpu_pkg::OP_SLT:  r.wr_data = ($signed(a) < $signed(b)) ? 16'd1 : 16'd0;
         cpu_pkg::OP_SEQ:  r.wr_data = (a == b) ? 16'd1 : 16'd0;
         cpu_pkg::OP_LBI:  r.wr_data = {{8{ins[7]}}, ins[7:0]};
         cpu_pkg::OP_SLBI: r.wr_data = (model_regs[rd] << 8) | {8'h00, ins[7:0]};
         cpu_pkg::OP_LD:   r.wr_data = model_mem[sum[7:0]];
         cpu_pkg::OP_ST: begin
            model_mem[sum[7:0]] = model_regs[rd];
            r.valid = 1'b0;
         end
         cpu_pkg::OP_HALT: begin
            model_halted = 1'b1;
            r.valid = 1'b0;
         end
         default: r.valid = 1'b0;
      endcase
      if (r.valid) begin
         model_regs[rd] = r.wr_data;
      end
      return r;
   endfunction

   // ==============================
   // stimulus helpers
   // ==============================
   task automatic issue(input logic [15:0] ins);
      cpu_pkg::wb_t exp_wb;
      exp_wb = predict(ins);
      if (exp_wb.valid) begin
         expected_q.push_back(exp_wb);
      end
      @(posedge clk);
      instr_valid <= 1'b1;
      instr       <= ins;
      @(posedge clk);
      instr_valid <= 1'b0;
      @(posedge clk);
   endtask

   // wait until every expected wb has been seen
   task automatic wait_drain();
      int n;
      n = 0;
      while (expected_q.size() != 0 && n < 10) begin
         @(negedge clk);
         n++;
      end
      if (expected_q.size() != 0) begin
         $display("%0d writeback results never arrived", expected_q.size());
         errors++;
      end
   endtask

   task automatic report_test(input int num, input string name, input int mark);
      wait_drain();
      if (errors == mark) begin
         tests_passed++;
         $display("test %0d %s: PASS", num, name);
      end else begin
         tests_failed++;
         $display("test %0d %s: FAIL (%0d errors)", num, name, errors - mark);
      end
   endtask

   // ==============================
   // checker
   // ==============================
   always @(negedge clk) begin
      cpu_pkg::wb_t exp_wb;
      if (!rst && wb.valid) begin
         if (expected_q.size() == 0) begin
            $display("a writeback to r%0d arrived at %0t with no result expected",
                     wb.wr_reg, $time);
            stray_wb++;
            errors++;
         end else begin
            exp_wb = expected_q.pop_front();
            checks++;
            assert (wb.wr_reg == exp_wb.wr_reg && wb.wr_data == exp_wb.wr_data) else begin
               $display("[ERROR] %0t: wb r%0d = %h, expected r%0d = %h", $time,
                        wb.wr_reg, wb.wr_data, exp_wb.wr_reg, exp_wb.wr_data);
               errors++;
            end
         end
      end
   end

   always @(posedge clk) begin
      cycles++;
      if (cycles > CYCLE_LIMIT) begin
         $display("run stopped after %0d cycles without finishing", cycles);
         $display("Simulation failed");
         $finish;
      end
   end

   // ==============================
   // tests
   // ==============================
   initial begin
      logic [31:0]      rnd;
      logic [7:0]       hi;
      logic [7:0]       lo;
      logic [4:0]       off;
      logic [2:0]       pa [5];
      logic [2:0]       pb [5];
      cpu_pkg::opcode_e op;
      int               mark;
      int               stray_mark;
      clk          = 1'b0;
      rst          = 1'b1;
      instr_valid  = 1'b0;
      instr        = '0;
      model_halted = 1'b0;
      pa           = '{3'd1, 3'd3, 3'd4, 3'd5, 3'd6};
      pb           = '{3'd2, 3'd4, 3'd3, 3'd6, 3'd5};
      for (int i = 0; i < cpu_pkg::NUM_REGS; i++) begin
         model_regs[i] = '0;
      end
      for (int i = 0; i < cpu_pkg::MEM_WORDS; i++) begin
         model_mem[i] = '0;
      end
      repeat (10) @(posedge clk);
      rst <= 1'b0;

      // 16-bit constants with r6 and r7 set up for wraparound
      mark = errors;
      for (int r = 0; r < 8; r++) begin
         rnd = $random(seed);
         hi  = rnd[7:0];
         lo  = rnd[15:8];
         if (r == 6) begin
            hi = 8'h7f;
            lo = 8'hff;
         end
         if (r == 7) begin
            hi = 8'h80;
            lo = 8'h01;
         end
         issue(btype(cpu_pkg::OP_LBI, 3'(r), hi));
         issue(btype(cpu_pkg::OP_SLBI, 3'(r), lo));
      end
      report_test(1, "lbi/slbi constants", mark);

      mark = errors;
      issue(rtype(cpu_pkg::OP_ADD, 3'd5, 3'd6, 3'd6));
      issue(rtype(cpu_pkg::OP_SUB, 3'd4, 3'd7, 3'd6));
      for (int i = 0; i < 38; i++) begin
         rnd = $random(seed);
         case (rnd[2:0])
            3'd0, 3'd5: op = cpu_pkg::OP_ADD;
            3'd1, 3'd6: op = cpu_pkg::OP_SUB;
            3'd2, 3'd7: op = cpu_pkg::OP_AND;
            3'd3:       op = cpu_pkg::OP_XOR;
            default:    op = cpu_pkg::OP_ADDI;
         endcase
         if (op == cpu_pkg::OP_ADDI) begin
            issue(itype(op, rnd[5:3], rnd[8:6], rnd[13:9]));
         end else begin
            issue(rtype(op, rnd[5:3], rnd[8:6], rnd[11:9]));
         end
      end
      report_test(2, "random alu", mark);

      // equal, mixed sign and overflow pairs
      mark = errors;
      issue(btype(cpu_pkg::OP_LBI, 3'd1, 8'd5));
      issue(btype(cpu_pkg::OP_LBI, 3'd2, 8'd5));
      issue(btype(cpu_pkg::OP_LBI, 3'd3, 8'hfd));
      issue(btype(cpu_pkg::OP_LBI, 3'd4, 8'd7));
      issue(btype(cpu_pkg::OP_LBI, 3'd5, 8'h7f));
      issue(btype(cpu_pkg::OP_SLBI, 3'd5, 8'hff));
      issue(btype(cpu_pkg::OP_LBI, 3'd6, 8'h80));
      issue(btype(cpu_pkg::OP_SLBI, 3'd6, 8'h00));
      for (int i = 0; i < 5; i++) begin
         issue(rtype(cpu_pkg::OP_SLT, 3'd0, pa[i], pb[i]));
         issue(rtype(cpu_pkg::OP_SEQ, 3'd7, pa[i], pb[i]));
      end
      report_test(3, "slt/seq", mark);

      mark = errors;
      for (int i = 0; i < 6; i++) begin
         rnd = $random(seed);
         off = (i == 0) ? 5'b11101 : rnd[12:8];
         issue(btype(cpu_pkg::OP_LBI, 3'd1, rnd[7:0]));
         issue(btype(cpu_pkg::OP_LBI, 3'd2, rnd[23:16]));
         issue(btype(cpu_pkg::OP_SLBI, 3'd2, rnd[31:24]));
         issue(itype(cpu_pkg::OP_ST, 3'd2, 3'd1, off));
         issue(itype(cpu_pkg::OP_LD, 3'd3, 3'd1, off));
      end
      report_test(4, "store/load", mark);

      mark = errors;
      stray_mark = stray_wb;
      // the instruction right behind HALT must already be refused
      void'(predict(btype(cpu_pkg::OP_HALT, 3'd0, 8'd0)));
      void'(predict(itype(cpu_pkg::OP_ADDI, 3'd5, 3'd5, 5'd3)));
      @(posedge clk);
      instr_valid <= 1'b1;
      instr       <= btype(cpu_pkg::OP_HALT, 3'd0, 8'd0);
      @(posedge clk);
      instr       <= itype(cpu_pkg::OP_ADDI, 3'd5, 3'd5, 5'd3);
      @(posedge clk);
      instr_valid <= 1'b0;
      for (int n = 0; n < 10 && !halted; n++) begin
         @(negedge clk);
      end
      assert (halted) else begin
         $display("halted did not rise after HALT");
         errors++;
      end
      // 20-cycle window with no writeback allowed
      issue(itype(cpu_pkg::OP_ADDI, 3'd1, 3'd1, 5'd1));
      issue(btype(cpu_pkg::OP_LBI, 3'd2, 8'h55));
      issue(rtype(cpu_pkg::OP_ADD, 3'd3, 3'd1, 3'd2));
      issue(itype(cpu_pkg::OP_LD, 3'd4, 3'd0, 5'd0));
      repeat (8) @(negedge clk);
      assert (stray_wb == stray_mark) else begin
         $display("instructions after HALT still wrote registers");
         errors++;
      end
      report_test(5, "halt", mark);

      $display("tests passed %0d, failed %0d, checks %0d, errors %0d",
               tests_passed, tests_failed, checks, errors);
      if (errors == 0) begin
         $display("Simulation completed successfully");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule

// ==== compile.f ====
rtl/cpu_pkg.sv
rtl/decode_stage.sv
rtl/execute_stage.sv
rtl/ex_mem.sv
rtl/memory_stage.sv
rtl/cpu_backend_top.sv
tests/tb_cpu_backend.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the cpu back end testbench with verilator

TOP=tb_cpu_backend
LOG=sim.log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module "$TOP" -f compile.f -o "$TOP" > build.log 2>&1
if [ $? -ne 0 ]; then
   cat build.log
   echo "verilator build failed"
   exit 1
fi

./obj_dir/"$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -q "Simulation failed" "$LOG"; then
   exit 1
fi
exit 0
